// File: verilog/motor_channel_pkg.sv
/* motor-side constants and types: channel count, d/q current pair,
   driver fault status word */
`default_nettype none

package motor_channel_pkg;

    localparam int num_channels = 4;             // motors served by one controller
    localparam int intflag_width = 3 * num_channels; // otw, driver fault and hall per motor

    // signed current sample as delivered by the current loop
    typedef logic signed [15:0] current_t;

    // d in the upper half, q in the lower half, as on the stream ports
    typedef struct packed {
        current_t d;                             // direct axis
        current_t q;                             // quadrature axis
    } current_pair_t;

    // status word in register order, all bits active low
    typedef struct packed {
        logic [num_channels-1:0] driver_otw_n;   // over-temperature warning
        logic [num_channels-1:0] driver_fault_n; // gate driver fault
        logic [num_channels-1:0] hall_fault_n;   // hall sensor pattern error
        logic [num_channels-1:0] encoder_fault_n; // reported only, no flag or fault
    } fault_status_t;

endpackage

`default_nettype wire

// File: verilog/motor_regs_pkg.sv
/* host register map: bus widths, word address enum and the FAULT command word */
`default_nettype none

package motor_regs_pkg;

    localparam int addr_width = 5;               // word address
    localparam int data_width = 16;              // bus data
    localparam int ch_reg_stride = 2;            // d and q word per motor

    // word addresses, 0x03..0x07 and 0x1a and up read as zero
    typedef enum logic [addr_width-1:0] {
        reg_status  = 5'h00,                     // live status inputs
        reg_intflag = 5'h01,                     // sticky flags, cleared by read
        reg_fault   = 5'h02,                     // fault and brake commands
        reg_imeasd0 = 5'h08,
        reg_imeasq0 = 5'h09,
        reg_imeasd1 = 5'h0a,
        reg_imeasq1 = 5'h0b,
        reg_imeasd2 = 5'h0c,
        reg_imeasq2 = 5'h0d,
        reg_imeasd3 = 5'h0e,
        reg_imeasq3 = 5'h0f,
        reg_irefd0  = 5'h10,
        reg_irefq0  = 5'h11,                     // q write fires the reference
        reg_irefd1  = 5'h12,
        reg_irefq1  = 5'h13,
        reg_irefd2  = 5'h14,
        reg_irefq2  = 5'h15,
        reg_irefd3  = 5'h16,
        reg_irefq3  = 5'h17,
        reg_kp      = 5'h18,                     // proportional gain
        reg_ki      = 5'h19                      // integral gain
    } reg_addr_e;

    // one brake command pair, clear above set
    typedef struct packed {
        logic clr;
        logic set;
    } brake_cmd_t;

    // FAULT register bits 9..0
    typedef struct packed {
        brake_cmd_t [motor_channel_pkg::num_channels-1:0] brake; // motor 3 in bits 9:8
        logic fault_clr;                         // bit 1
        logic fault_set;                         // bit 0, wins over clear
    } fault_cmd_t;

    localparam int fault_cmd_width = $bits(fault_cmd_t);
    localparam logic [3:0] intflag_reserved = 4'hf; // INTFLAG low nibble
endpackage

`default_nettype wire

// File: verilog/fault_monitor.sv
/* fault_monitor: fault and short-brake state, falling-edge interrupt flags
   with clear on read, registered interrupt output */
`timescale 1ns/1ps
`default_nettype none

module fault_monitor (
    input  logic                                     clk,
    input  logic                                     reset,
    input  motor_channel_pkg::fault_status_t         status,
    input  motor_regs_pkg::fault_cmd_t               fault_cmd,     // one-cycle command
    input  logic                                     intflag_clear, // INTFLAG was read
    output logic                                     fault,
    output logic [motor_channel_pkg::num_channels-1:0] brake,
    output logic [motor_channel_pkg::intflag_width-1:0] intflags,   // active low
    output logic                                     irq
);

    localparam int nch = motor_channel_pkg::num_channels;
    localparam int nfl = motor_channel_pkg::intflag_width;

    logic [nfl-1:0] sense_n;                     // live inputs that raise flags
    logic [nfl-1:0] sense_prev_n;                // last sample, masked by fault_clr
    logic [nfl-1:0] falling;                     // high to low seen this edge
    logic           any_low;                     // some watched input asserted

    // encoder faults are reported in STATUS only
    assign sense_n = {status.driver_otw_n, status.driver_fault_n, status.hall_fault_n};
    assign falling = sense_prev_n & ~sense_n;
    assign any_low = ~&sense_n;

    // fault bit
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            fault <= 1'b0;
        end else if (any_low) begin
            fault <= 1'b1;                       // forced while an input is low
        end else begin
            fault <= (fault & ~fault_cmd.fault_clr) | fault_cmd.fault_set; // set has priority
        end
    end

    // short brake per motor, no link to status
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            brake <= '0;
        end else begin
            for (int i = 0; i < nch; i++) begin
                brake[i] <= (brake[i] & ~fault_cmd.brake[i].clr) | fault_cmd.brake[i].set;
            end
        end
    end

    // edge detect and sticky flags
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            sense_prev_n <= '1;
            intflags     <= '1;
        end else begin
            // a clear re-arms inputs that stay low
            sense_prev_n <= sense_n | {nfl{fault_cmd.fault_clr}};
            // read restores ones, a new edge on the same clock still wins
            intflags     <= (intflags | {nfl{intflag_clear}}) & ~falling;
        end
    end

    // interrupt follows the flags one clock later
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            irq <= 1'b0;
        end else begin
            irq <= ~&intflags;                   // any flag low
        end
    end

endmodule

`default_nettype wire

// File: verilog/current_channel.sv
/* current_channel: measurement capture and d/q reference holding for one motor,
   with the reference valid pulse on a q write */
`timescale 1ns/1ps
`default_nettype none

module current_channel (
    input  logic                             clk,
    input  logic                             reset,
    input  motor_channel_pkg::current_pair_t measurement_data,  // from current sensing
    input  logic                             measurement_valid,
    input  logic                             ref_wr_d,          // IREFD write this cycle
    input  logic                             ref_wr_q,          // IREFQ write this cycle
    input  motor_channel_pkg::current_t      ref_wdata,
    output motor_channel_pkg::current_pair_t measurement,       // last captured pair
    output motor_channel_pkg::current_pair_t reference_data,
    output logic                             reference_valid    // one cycle per q write
);

    // measurement sample, only loaded on the strobe
    always_ff @(posedge clk) begin
        if (measurement_valid) begin
            measurement <= measurement_data;
        end
    end

    // reference halves written separately by the host
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            reference_data <= '0;
        end else begin
            if (ref_wr_d) begin
                reference_data.d <= ref_wdata;   // held until the q write
            end
            if (ref_wr_q) begin
                reference_data.q <= ref_wdata;
            end
        end
    end

    // the q write sends the pair, d is usually left at zero
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            reference_valid <= 1'b0;
        end else begin
            reference_valid <= ref_wr_q;         // lines up with the new q half
        end
    end

endmodule

`default_nettype wire

// File: verilog/register_slave.sv
/* register_slave: bus write decode into command strobes and reference enables,
   gain registers and the registered read mux */
`timescale 1ns/1ps
`default_nettype none

module register_slave (
    input  logic                                          clk,
    input  logic                                          reset,
    input  logic [motor_regs_pkg::addr_width-1:0]         address,
    input  logic                                          read,
    input  logic                                          write,
    input  logic [motor_regs_pkg::data_width-1:0]         writedata,
    output logic [motor_regs_pkg::data_width-1:0]         readdata,  // one cycle after read
    input  motor_channel_pkg::fault_status_t              status,
    input  logic [motor_channel_pkg::intflag_width-1:0]   intflags,
    input  logic                                          fault,
    input  logic [motor_channel_pkg::num_channels-1:0]    brake,
    input  motor_channel_pkg::current_pair_t [motor_channel_pkg::num_channels-1:0] measurement,
    input  motor_channel_pkg::current_pair_t [motor_channel_pkg::num_channels-1:0] reference,
    output motor_regs_pkg::fault_cmd_t                    fault_cmd,     // zero unless written
    output logic                                          intflag_clear, // registered read strobe
    output logic [motor_channel_pkg::num_channels-1:0]    ref_wr_d,      // one-hot per motor
    output logic [motor_channel_pkg::num_channels-1:0]    ref_wr_q,
    output motor_channel_pkg::current_t                   ref_wdata,
    output logic [motor_regs_pkg::data_width-1:0]         param_kp,
    output logic [motor_regs_pkg::data_width-1:0]         param_ki
);

    localparam int nch = motor_channel_pkg::num_channels;
    localparam int aw  = motor_regs_pkg::addr_width;
    localparam int dw  = motor_regs_pkg::data_width;
    localparam int fcw = motor_regs_pkg::fault_cmd_width;

    motor_regs_pkg::fault_cmd_t fault_rd;        // FAULT read image
    logic [dw-1:0]              rd_word;         // read mux output

    // word address of motor ch, counted from the motor 0 register
    function automatic logic [aw-1:0] chan_addr(input motor_regs_pkg::reg_addr_e base,
                                                 input int ch);
        return aw'(int'(base) + motor_regs_pkg::ch_reg_stride * ch);
    endfunction

    // reference writes go straight to the channels
    assign ref_wdata = motor_channel_pkg::current_t'(writedata);

    always_comb begin
        ref_wr_d = '0;
        ref_wr_q = '0;
        for (int i = 0; i < nch; i++) begin
            ref_wr_d[i] = write && (address == chan_addr(motor_regs_pkg::reg_irefd0, i));
            ref_wr_q[i] = write && (address == chan_addr(motor_regs_pkg::reg_irefq0, i));
        end
    end

    // command strobes, one cycle long
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            fault_cmd     <= '0;
            intflag_clear <= 1'b0;
        end else begin
            if (write && (address == motor_regs_pkg::reg_fault)) begin
                fault_cmd <= motor_regs_pkg::fault_cmd_t'(writedata[fcw-1:0]);
            end else begin
                fault_cmd <= '0;                 // idle cycles carry no command
            end
            intflag_clear <= read && (address == motor_regs_pkg::reg_intflag);
        end
    end

    // current loop gains
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            param_kp <= '0;
            param_ki <= '0;
        end else if (write) begin
            if (address == motor_regs_pkg::reg_kp) begin
                param_kp <= writedata;
            end
            if (address == motor_regs_pkg::reg_ki) begin
                param_ki <= writedata;
            end
        end
    end

    // FAULT reads show state in the set positions, clear bits read zero
    always_comb begin
        fault_rd = '0;
        fault_rd.fault_set = fault;
        for (int i = 0; i < nch; i++) begin
            fault_rd.brake[i].set = brake[i];
        end
    end

    always_comb begin
        rd_word = '0;                            // holes and unmapped words
        case (address)
            motor_regs_pkg::reg_status:  rd_word = status;
            motor_regs_pkg::reg_intflag: rd_word = {intflags, motor_regs_pkg::intflag_reserved};
            motor_regs_pkg::reg_fault:   rd_word = {{(dw-fcw){1'b0}}, fault_rd};
            motor_regs_pkg::reg_kp:      rd_word = param_kp;
            motor_regs_pkg::reg_ki:      rd_word = param_ki;
            default: begin
                // per-motor measurement and reference words
                for (int i = 0; i < nch; i++) begin
                    if (address == chan_addr(motor_regs_pkg::reg_imeasd0, i)) begin
                        rd_word = measurement[i].d;
                    end
                    if (address == chan_addr(motor_regs_pkg::reg_imeasq0, i)) begin
                        rd_word = measurement[i].q;
                    end
                    if (address == chan_addr(motor_regs_pkg::reg_irefd0, i)) begin
                        rd_word = reference[i].d;
                    end
                    if (address == chan_addr(motor_regs_pkg::reg_irefq0, i)) begin
                        rd_word = reference[i].q;
                    end
                end
            end
        endcase
    end

    // read data register, holds between reads
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            readdata <= '0;
        end else if (read) begin
            readdata <= rd_word;
        end
    end

endmodule

`default_nettype wire

// File: verilog/vector_controller_master.sv
/* vector_controller_master: host register front end joining the register slave,
   fault monitor and per-motor current channels */
`timescale 1ns/1ps
`default_nettype none

module vector_controller_master (
    input  logic                                          clk,
    input  logic                                          reset,
    output logic                                          fault,       // to gate drivers
    output logic [motor_channel_pkg::num_channels-1:0]    brake,       // short brake per motor
    input  motor_channel_pkg::fault_status_t              status,
    output logic [motor_regs_pkg::data_width-1:0]         param_kp,
    output logic [motor_regs_pkg::data_width-1:0]         param_ki,
    input  motor_channel_pkg::current_pair_t [motor_channel_pkg::num_channels-1:0]
                                                          measurement_data,
    input  logic [motor_channel_pkg::num_channels-1:0]    measurement_valid,
    output motor_channel_pkg::current_pair_t [motor_channel_pkg::num_channels-1:0]
                                                          reference_data,
    output logic [motor_channel_pkg::num_channels-1:0]    reference_valid,
    input  logic [motor_regs_pkg::addr_width-1:0]         address,     // host bus
    input  logic                                          read,
    input  logic                                          write,
    input  logic [motor_regs_pkg::data_width-1:0]         writedata,
    output logic [motor_regs_pkg::data_width-1:0]         readdata,
    output logic                                          irq          // to host
);

    localparam int nch = motor_channel_pkg::num_channels;

    motor_regs_pkg::fault_cmd_t                   fault_cmd;     // slave to monitor
    logic                                         intflag_clear;
    logic [motor_channel_pkg::intflag_width-1:0]  intflags;      // monitor to slave
    logic [nch-1:0]                               ref_wr_d;      // slave to channels
    logic [nch-1:0]                               ref_wr_q;
    motor_channel_pkg::current_t                  ref_wdata;
    motor_channel_pkg::current_pair_t [nch-1:0]   measurement;   // captured samples

    register_slave u_register_slave (
        .clk           (clk),
        .reset         (reset),
        .address       (address),
        .read          (read),
        .write         (write),
        .writedata     (writedata),
        .readdata      (readdata),
        .status        (status),
        .intflags      (intflags),
        .fault         (fault),
        .brake         (brake),
        .measurement   (measurement),
        .reference     (reference_data),        // read back from the channel outputs
        .fault_cmd     (fault_cmd),
        .intflag_clear (intflag_clear),
        .ref_wr_d      (ref_wr_d),
        .ref_wr_q      (ref_wr_q),
        .ref_wdata     (ref_wdata),
        .param_kp      (param_kp),
        .param_ki      (param_ki)
    );

    fault_monitor u_fault_monitor (
        .clk           (clk),
        .reset         (reset),
        .status        (status),
        .fault_cmd     (fault_cmd),
        .intflag_clear (intflag_clear),
        .fault         (fault),
        .brake         (brake),
        .intflags      (intflags),
        .irq           (irq)
    );

    // one channel per motor, sharing the write data
    for (genvar i = 0; i < nch; i++) begin : g_channel
        current_channel u_current_channel (
            .clk               (clk),
            .reset             (reset),
            .measurement_data  (measurement_data[i]),
            .measurement_valid (measurement_valid[i]),
            .ref_wr_d          (ref_wr_d[i]),
            .ref_wr_q          (ref_wr_q[i]),
            .ref_wdata         (ref_wdata),
            .measurement       (measurement[i]),
            .reference_data    (reference_data[i]),
            .reference_valid   (reference_valid[i])
        );
    end

endmodule

`default_nettype wire

// File: tb/tb_vector_controller_master.sv
/* testbench for vector_controller_master with a step table applied in a loop
   against a register model, per-test report and watchdog */
`timescale 1ns/1ps
`default_nettype none

module tb_vector_controller_master;

    localparam int nch = motor_channel_pkg::num_channels;
    localparam int clk_period = 4;
    localparam logic [4:0] a_status  = 5'h00;
    localparam logic [4:0] a_intflag = 5'h01;
    localparam logic [4:0] a_fault   = 5'h02;
    localparam logic [4:0] a_imeasd0 = 5'h08;
    localparam logic [4:0] a_irefd0  = 5'h10;
    localparam logic [4:0] a_kp      = 5'h18;
    localparam logic [4:0] a_ki      = 5'h19;

    typedef enum logic [1:0] {op_write, op_read, op_status, op_meas} op_e;

    typedef struct packed {
        logic [2:0]  test;                       // test group 1..5
        op_e         op;
        logic [1:0]  ch;                         // motor for op_meas
        logic [4:0]  addr;
        logic [31:0] data;
        logic        rnd;                        // take data from xorshift
        logic        valid;                      // strobe with op_meas
        logic        use_exp;                    // compare with exp instead of the model
        logic [15:0] exp;
    } step_t;

    logic                                       clk;
    logic                                       reset;
    logic                                       fault;
    logic [nch-1:0]                             brake;
    motor_channel_pkg::fault_status_t           status;
    logic [15:0]                                param_kp;
    logic [15:0]                                param_ki;
    motor_channel_pkg::current_pair_t [nch-1:0] measurement_data;
    logic [nch-1:0]                             measurement_valid;
    motor_channel_pkg::current_pair_t [nch-1:0] reference_data;
    logic [nch-1:0]                             reference_valid;
    logic [4:0]                                 address;
    logic                                       read;
    logic                                       write;
    logic [15:0]                                writedata;
    logic [15:0]                                readdata;
    logic                                       irq;

    logic [15:0]                      m_status;  // model of the register front end
    logic                             m_fault;
    logic [nch-1:0]                   m_brake;
    logic [11:0]                      m_flags;   // INTFLAG bits 15:4, active low
    logic [15:0]                      m_kp;
    logic [15:0]                      m_ki;
    motor_channel_pkg::current_pair_t m_ref [nch];
    motor_channel_pkg::current_pair_t m_meas [nch];

    step_t steps[$];
    int    n_steps = 0;
    int    checks = 0;
    int    errors = 0;
    int    test_checks = 0;
    int    test_errors = 0;

    vector_controller_master dut0 (.*);

    initial begin
        clk = 1'b0;
        forever #(clk_period / 2) clk = ~clk;
    end

    function automatic logic [31:0] xorshift(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    // read word as the register map defines it
    function automatic logic [15:0] expected_read(input logic [4:0] a);
        logic [15:0] w;
        w = '0;                                  // holes and unmapped words
        case (a)
            a_status:  w = m_status;
            a_intflag: w = {m_flags, 4'hf};
            a_fault: begin
                w[0] = m_fault;
                for (int b = 0; b < nch; b++) begin
                    w[2 + 2*b] = m_brake[b];     // set-bit position of each pair
                end
            end
            a_kp:      w = m_kp;
            a_ki:      w = m_ki;
            default: begin
                if (a >= a_imeasd0 && a < a_irefd0) begin
                    w = a[0] ? m_meas[a[2:1]].q : m_meas[a[2:1]].d;
                end else if (a >= a_irefd0 && a < a_kp) begin
                    w = a[0] ? m_ref[a[2:1]].q : m_ref[a[2:1]].d;
                end
            end
        endcase
        return w;
    endfunction

    task automatic update_on_write(input logic [4:0] a, input logic [15:0] d);
        if (a == a_fault) begin
            for (int b = 0; b < nch; b++) begin
                m_brake[b] = (m_brake[b] & ~d[3 + 2*b]) | d[2 + 2*b]; // set wins
            end
            if (&m_status[15:4]) begin
                m_fault = (m_fault & ~d[1]) | d[0]; // forced high while an input is low
            end
            if (d[1]) begin
                m_flags = m_flags & m_status[15:4]; // inputs still low flag again
            end
        end else if (a == a_kp) begin
            m_kp = d;
        end else if (a == a_ki) begin
            m_ki = d;
        end else if (a >= a_irefd0 && a < a_kp) begin
            if (a[0]) begin
                m_ref[a[2:1]].q = d;
            end else begin
                m_ref[a[2:1]].d = d;
            end
        end
    endtask

    task automatic update_on_status(input logic [15:0] d);
        m_flags = m_flags & ~(m_status[15:4] & ~d[15:4]); // falling inputs only
        if (!(&d[15:4])) begin
            m_fault = 1'b1;
        end
        m_status = d;
    endtask

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        checks++;
        test_checks++;
        assert (got === exp) else begin
            $display("Error: %s got %h expected %h", name, got, exp);
            errors++;
            test_errors++;
        end
    endtask

    task automatic write_register(input logic [4:0] a, input logic [15:0] d);
        logic [3:0] exp_valid;
        exp_valid = '0;
        if (a >= a_irefd0 && a < a_kp && a[0]) begin
            exp_valid[a[2:1]] = 1'b1;            // q half fires the pair
        end
        @(posedge clk);
        write     <= 1'b1;
        address   <= a;
        writedata <= d;
        @(posedge clk);
        write <= 1'b0;
        update_on_write(a, d);
        @(negedge clk);
        check_value("reference_valid", 32'(reference_valid), 32'(exp_valid));
        if (exp_valid != 4'h0) begin
            check_value("reference_data", reference_data[a[2:1]], m_ref[a[2:1]]);
        end
        @(negedge clk);
        check_value("reference_valid", 32'(reference_valid), 32'h0); // one cycle only
        if (a == a_fault) begin
            check_value("fault", 32'(fault), 32'(m_fault)); // two edges after the write
            check_value("brake", 32'(brake), 32'(m_brake));
        end
    endtask

    task automatic read_and_check(input logic [4:0] a, input logic use_exp,
                                  input logic [15:0] exp);
        logic [15:0] want;
        want = use_exp ? exp : expected_read(a);
        @(posedge clk);
        read    <= 1'b1;
        address <= a;
        @(posedge clk);
        read <= 1'b0;
        @(negedge clk);
        check_value("readdata", 32'(readdata), 32'(want));
        if (a == a_intflag) begin
            m_flags = '1;                        // read restores the flags
        end
    endtask

    task automatic drive_status(input logic [15:0] d);
        @(posedge clk);
        status <= d;
        update_on_status(d);
    endtask

    task automatic pulse_measurement(input logic [1:0] c, input logic [31:0] d,
                                     input logic v);
        @(posedge clk);
        measurement_data[c]  <= d;
        measurement_valid[c] <= v;
        @(posedge clk);
        measurement_valid <= '0;
        if (v) begin
            m_meas[c] = d;
        end
    endtask

    // irq lags the flags by one edge so outputs are checked two edges on
    task automatic settle_and_check();
        repeat (2) @(posedge clk);
        @(negedge clk);
        check_value("fault", 32'(fault), 32'(m_fault));
        check_value("brake", 32'(brake), 32'(m_brake));
        check_value("irq", 32'(irq), 32'(~&m_flags));
        check_value("param_kp", 32'(param_kp), 32'(m_kp));
        check_value("param_ki", 32'(param_ki), 32'(m_ki));
        for (int c = 0; c < nch; c++) begin
            check_value("reference_data", reference_data[c], m_ref[c]);
        end
    endtask

    task automatic add_write(input logic [2:0] t, input logic [4:0] a,
                             input logic [15:0] d, input logic r);
        step_t s;
        s = '0;
        s.test = t;
        s.op   = op_write;
        s.addr = a;
        s.data = 32'(d);
        s.rnd  = r;
        steps.push_back(s);
    endtask

    task automatic add_read(input logic [2:0] t, input logic [4:0] a,
                            input logic u, input logic [15:0] e);
        step_t s;
        s = '0;
        s.test    = t;
        s.op      = op_read;
        s.addr    = a;
        s.use_exp = u;
        s.exp     = e;
        steps.push_back(s);
    endtask

    task automatic add_status(input logic [2:0] t, input logic [15:0] d);
        step_t s;
        s = '0;
        s.test = t;
        s.op   = op_status;
        s.data = 32'(d);
        steps.push_back(s);
    endtask

    task automatic add_measurement(input logic [2:0] t, input logic [1:0] c, input logic v);
        step_t s;
        s = '0;
        s.test  = t;
        s.op    = op_meas;
        s.ch    = c;
        s.rnd   = 1'b1;
        s.valid = v;
        steps.push_back(s);
    endtask

    task automatic build_table();
        logic [15:0] cmds [6] = '{16'h001, 16'h002, 16'h003, 16'h154, 16'h220, 16'h00c};
        logic [4:0]  holes [4] = '{5'h03, 5'h07, 5'h1a, 5'h1f};
        add_read(3'd1, a_intflag, 1'b1, 16'hffff);
        add_read(3'd1, a_fault, 1'b1, 16'h0000);
        add_read(3'd1, a_kp, 1'b1, 16'h0000);
        add_read(3'd1, a_irefd0 + 5'd1, 1'b1, 16'h0000);
        for (int c = 0; c < nch; c++) begin
            add_write(3'd2, a_irefd0 + 5'(2*c), 16'h0, 1'b1);
            add_write(3'd2, a_irefd0 + 5'(2*c + 1), 16'h0, 1'b1);
            add_read(3'd2, a_irefd0 + 5'(2*c), 1'b0, 16'h0);
            add_read(3'd2, a_irefd0 + 5'(2*c + 1), 1'b0, 16'h0);
        end
        add_write(3'd2, a_irefd0, 16'h0, 1'b1);  // d alone sends nothing
        add_write(3'd2, a_kp, 16'h0, 1'b1);
        add_write(3'd2, a_ki, 16'h0, 1'b1);
        add_read(3'd2, a_kp, 1'b0, 16'h0);
        add_read(3'd2, a_ki, 1'b0, 16'h0);
        for (int c = 0; c < nch; c++) begin
            add_measurement(3'd3, 2'(c), 1'b1);
            add_read(3'd3, a_imeasd0 + 5'(2*c), 1'b0, 16'h0);
            add_read(3'd3, a_imeasd0 + 5'(2*c + 1), 1'b0, 16'h0);
        end
        add_measurement(3'd3, 2'd1, 1'b0);       // new data without the strobe
        add_read(3'd3, a_imeasd0 + 5'd2, 1'b0, 16'h0);
        add_read(3'd3, a_imeasd0 + 5'd3, 1'b0, 16'h0);
        foreach (cmds[i]) begin
            add_write(3'd4, a_fault, cmds[i], 1'b0);
            add_read(3'd4, a_fault, 1'b0, 16'h0);
        end
        add_write(3'd4, a_fault, 16'h0, 1'b1);
        add_read(3'd4, a_fault, 1'b0, 16'h0);
        add_write(3'd4, a_fault, 16'h2aa, 1'b0); // every clear bit
        add_read(3'd4, a_fault, 1'b1, 16'h0000);
        add_read(3'd5, a_status, 1'b1, 16'hffff);
        add_status(3'd5, 16'hffbf);              // hall fault on motor 2
        add_read(3'd5, a_status, 1'b0, 16'h0);
        add_read(3'd5, a_intflag, 1'b1, 16'hffbf);
        add_read(3'd5, a_intflag, 1'b0, 16'h0);
        add_write(3'd5, a_fault, 16'h002, 1'b0); // clear while the hall input stays low
        add_read(3'd5, a_intflag, 1'b1, 16'hffbf);
        add_status(3'd5, 16'hffff);
        add_write(3'd5, a_fault, 16'h002, 1'b0);
        add_status(3'd5, 16'hfdff);              // driver fault on motor 1
        add_status(3'd5, 16'hffff);
        add_read(3'd5, a_intflag, 1'b1, 16'hfdff);
        add_read(3'd5, a_intflag, 1'b1, 16'hffff);
        add_write(3'd5, a_fault, 16'h002, 1'b0);
        add_status(3'd5, 16'hfffe);              // encoder bit raises nothing
        add_read(3'd5, a_status, 1'b1, 16'hfffe);
        add_status(3'd5, 16'hffff);
        foreach (holes[i]) begin
            add_read(3'd5, holes[i], 1'b1, 16'h0000);
        end
    endtask

    function automatic string test_name(input logic [2:0] t);
        case (t)
            3'd1:    return "reset values";
            3'd2:    return "reference writes";
            3'd3:    return "measurement capture";
            3'd4:    return "fault commands";
            default: return "status and interrupts";
        endcase
    endfunction

    task automatic report_test(input logic [2:0] t);
        $display("test %0d %s: %0d checks, %0d errors", t, test_name(t), test_checks,
                 test_errors);
        test_checks = 0;
        test_errors = 0;
    endtask

    initial begin
        step_t       s;
        logic [2:0]  cur_test;
        logic [31:0] d;
        logic [31:0] seed;
        seed              = 32'h9989;
        reset             = 1'b1;
        status            = '1;                  // all inputs inactive
        measurement_data  = '0;
        measurement_valid = '0;
        address           = '0;
        read              = 1'b0;
        write             = 1'b0;
        writedata         = '0;
        m_status          = 16'hffff;
        m_fault           = 1'b0;
        m_brake           = '0;
        m_flags           = '1;
        m_kp              = '0;
        m_ki              = '0;
        for (int c = 0; c < nch; c++) begin
            m_ref[c] = '0;
        end
        build_table();
        n_steps = steps.size();
        repeat (4) @(posedge clk);
        reset <= 1'b0;
        cur_test = steps[0].test;
        foreach (steps[n]) begin
            s = steps[n];
            if (s.test != cur_test) begin
                report_test(cur_test);
                cur_test = s.test;
            end
            d = s.data;
            if (s.rnd) begin
                seed = xorshift(seed);
                d    = seed;
            end
            case (s.op)
                op_write:  write_register(s.addr, d[15:0]);
                op_read:   read_and_check(s.addr, s.use_exp, s.exp);
                op_status: drive_status(d[15:0]);
                default:   pulse_measurement(s.ch, d, s.valid);
            endcase
            settle_and_check();
        end
        report_test(cur_test);
        $display("all tests: %0d checks, %0d errors", checks, errors);
        if (errors == 0) begin
            $display("Testbench passed");
        end else begin
            $display("Testbench failed");
        end
        $finish;
    end

    // each step takes well under 20 cycles
    initial begin
        wait (n_steps > 0);
        repeat (n_steps * 20) @(posedge clk);
        $display("watchdog expired before all steps finished");
        $display("Testbench failed");
        $finish;
    end

endmodule

`default_nettype wire

// File: build.f
verilog/motor_channel_pkg.sv
verilog/motor_regs_pkg.sv
verilog/fault_monitor.sv
verilog/current_channel.sv
verilog/register_slave.sv
verilog/vector_controller_master.sv
tb/tb_vector_controller_master.sv

// File: run_sim.sh
#!/usr/bin/env bash
# build and run the testbench with Verilator
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert --timescale 1ns/1ps -f build.f \
    --top-module tb_vector_controller_master -o sim_tb
output="$(./obj_dir/sim_tb)"
echo "$output"
if echo "$output" | grep -qx "Testbench passed"; then
    exit 0
fi
exit 1
